//--- design/eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

    // Line framing.
    localparam int PREAMBLE_LEN = 7;
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE = 8'hD5;
    localparam int HDR_LEN = 42;       // MAC 14, IPv4 20, UDP 8.
    localparam int FCS_LEN = 4;
    localparam int IFG_LEN = 12;

    // Protocol fields.
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0] IP_VER_IHL = 8'h45;
    localparam logic [7:0] IP_PROTO_UDP = 8'h11;
    localparam logic [7:0] IP_TTL = 8'd64;
    localparam logic [15:0] IPV4_HDR_LEN = 16'd20;
    localparam logic [15:0] UDP_HDR_LEN = 16'd8;

    // CRC-32 polynomial 0x04C11DB7, bit-reversed for the LSB-first shift.
    localparam logic [31:0] CRC32_POLY_REFL = 32'hEDB8_8320;
    localparam logic [31:0] CRC32_INIT = 32'hFFFF_FFFF;

    localparam int FIFO_DEPTH = 64;
    localparam int MIN_DATA_LEN = 18;  // Keeps every frame at or above 64 bytes.

    typedef struct packed {
        logic [47:0] src_mac;
        logic [47:0] dst_mac;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] data_len;
    } tx_cfg_t;

    typedef enum logic [3:0] {
        SRC_MAC_HI = 4'd0,
        SRC_MAC_LO = 4'd1,
        DST_MAC_HI = 4'd2,
        DST_MAC_LO = 4'd3,
        SRC_IP     = 4'd4,
        DST_IP     = 4'd5,
        PORTS      = 4'd6,
        DATA_LEN   = 4'd7
    } cfg_addr_e;

    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        PREAMBLE = 3'd1,
        SFD      = 3'd2,
        HEADER   = 3'd3,
        PAYLOAD  = 3'd4,
        FCS      = 3'd5,
        GAP      = 3'd6
    } tx_state_e;

endpackage

`default_nettype wire

//--- design/tx_config_regs.sv
`timescale 1ns/1ns
`default_nettype none

module tx_config_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cfg_we,
    input  eth_tx_pkg::cfg_addr_e cfg_addr,
    input  logic [31:0]           cfg_wdata,
    output eth_tx_pkg::tx_cfg_t   cfg
);
    import eth_tx_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg <= '0;
            cfg.data_len <= 16'(MIN_DATA_LEN);
        end else if (cfg_we) begin
            case (cfg_addr)
                // The upper MAC halves sit in the low 16 bits of the data word.
                SRC_MAC_HI: begin
                    cfg.src_mac[47:32] <= cfg_wdata[15:0];
                end
                SRC_MAC_LO: begin
                    cfg.src_mac[31:0] <= cfg_wdata;
                end
                DST_MAC_HI: begin
                    cfg.dst_mac[47:32] <= cfg_wdata[15:0];
                end
                DST_MAC_LO: begin
                    cfg.dst_mac[31:0] <= cfg_wdata;
                end
                SRC_IP: begin
                    cfg.src_ip <= cfg_wdata;
                end
                DST_IP: begin
                    cfg.dst_ip <= cfg_wdata;
                end
                PORTS: begin
                    cfg.src_port <= cfg_wdata[31:16];
                    cfg.dst_port <= cfg_wdata[15:0];
                end
                DATA_LEN: begin
                    cfg.data_len <= cfg_wdata[15:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/payload_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module payload_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic       we,
    input  logic [7:0] wr_data,
    input  logic       re,
    output logic [7:0] rd_data,
    output logic [6:0] count,
    output logic       full
);
    import eth_tx_pkg::*;

    logic [7:0]                    mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic                          wr_ok;
    logic                          rd_ok;

    assign full = (count == 7'(FIFO_DEPTH));
    assign wr_ok = we && !full;              // Writes into a full buffer are lost.
    assign rd_ok = re && (count != 7'd0);
    assign rd_data = mem[rd_ptr];            // Head byte is visible before the read.

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10: count <= count + 7'd1;
                2'b01: count <= count - 7'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/crc32_gen.sv
`timescale 1ns/1ns
`default_nettype none

module crc32_gen (
    input  logic        clk,
    input  logic        rst,
    input  logic        clr,
    input  logic        en,
    input  logic [7:0]  din,
    output logic [31:0] crc
);
    import eth_tx_pkg::*;

    logic [31:0] crc_next;

    // Ethernet sends each byte LSB first, so the register shifts right.
    always_comb begin
        crc_next = crc;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ din[i]) begin
                crc_next = (crc_next >> 1) ^ CRC32_POLY_REFL;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc <= CRC32_INIT;
        end else if (clr) begin
            crc <= CRC32_INIT;
        end else if (en) begin
            crc <= crc_next;
        end
    end

    // The sequencer inverts the register when it sends the FCS.

endmodule

`default_nettype wire

//--- design/header_gen.sv
`timescale 1ns/1ns
`default_nettype none

module header_gen (
    input  logic                clk,
    input  logic                rst,
    input  eth_tx_pkg::tx_cfg_t cfg,
    input  logic                frame_start,
    input  logic [5:0]          hdr_idx,
    output logic [7:0]          hdr_byte
);
    import eth_tx_pkg::*;

    tx_cfg_t                 cfg_q;
    logic [15:0]             ident_cnt;
    logic [15:0]             ident_q;
    logic [15:0]             ip_len;
    logic [15:0]             ip_len_q;
    logic [15:0]             udp_len_q;
    logic [15:0]             csum_q;
    logic [19:0]             csum_sum;
    logic [16:0]             csum_fold;
    logic [15:0]             csum;
    logic [0:HDR_LEN-1][7:0] hdr_bytes;

    assign ip_len = cfg.data_len + IPV4_HDR_LEN + UDP_HDR_LEN;

    // Flags/fragment and the checksum field itself are zero and drop out of the sum.
    always_comb begin
        csum_sum = 20'({IP_VER_IHL, 8'h00}) + 20'(ip_len) + 20'(ident_cnt)
                 + 20'({IP_TTL, IP_PROTO_UDP})
                 + 20'(cfg.src_ip[31:16]) + 20'(cfg.src_ip[15:0])
                 + 20'(cfg.dst_ip[31:16]) + 20'(cfg.dst_ip[15:0]);
        csum_fold = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);
        csum = ~(csum_fold[15:0] + 16'(csum_fold[16]));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ident_cnt <= '0;
        end else if (frame_start) begin
            ident_cnt <= ident_cnt + 16'd1;
        end
    end

    // Everything the header shows is frozen for the length of the frame.
    always_ff @(posedge clk) begin
        if (frame_start) begin
            cfg_q <= cfg;
            ident_q <= ident_cnt;
            ip_len_q <= ip_len;
            udp_len_q <= cfg.data_len + UDP_HDR_LEN;
            csum_q <= csum;
        end
    end

    assign hdr_bytes = {
        cfg_q.dst_mac, cfg_q.src_mac, ETH_TYPE_IPV4,
        IP_VER_IHL, 8'h00, ip_len_q, ident_q,
        16'h0000, IP_TTL, IP_PROTO_UDP, csum_q,
        cfg_q.src_ip, cfg_q.dst_ip,
        cfg_q.src_port, cfg_q.dst_port, udp_len_q,
        16'h0000                                    // UDP checksum is not used.
    };

    assign hdr_byte = (hdr_idx < 6'(HDR_LEN)) ? hdr_bytes[hdr_idx] : 8'h00;

endmodule

`default_nettype wire

//--- design/frame_tx.sv
`timescale 1ns/1ns
`default_nettype none

module frame_tx (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  eth_tx_pkg::tx_cfg_t cfg,
    input  logic [6:0]          fifo_count,
    input  logic [7:0]          fifo_data,
    output logic                fifo_re,
    input  logic [7:0]          hdr_byte,
    output logic [5:0]          hdr_idx,
    output logic                frame_start,
    input  logic [31:0]         crc,
    output logic                crc_clr,
    output logic                crc_en,
    output logic [7:0]          crc_din,
    output logic [7:0]          eth_txd,
    output logic                eth_txen,
    output logic                done,
    output logic                busy
);
    import eth_tx_pkg::*;

    tx_state_e   state;
    tx_state_e   next_state;
    logic [15:0] cnt;
    logic [15:0] len_q;
    logic        last;
    logic        start_ok;
    logic [31:0] fcs;
    logic [7:0]  tx_byte;

    // A frame only starts once the whole payload is already buffered.
    assign start_ok = (state == IDLE) && start && ({9'd0, fifo_count} >= cfg.data_len);

    always_comb begin
        next_state = state;
        last = 1'b0;
        case (state)
            IDLE: if (start_ok) next_state = PREAMBLE;
            PREAMBLE: last = (cnt == 16'(PREAMBLE_LEN - 1));
            SFD: last = 1'b1;
            HEADER: last = (cnt == 16'(HDR_LEN - 1));
            PAYLOAD: last = (cnt == len_q - 16'd1);
            FCS: last = (cnt == 16'(FCS_LEN - 1));
            GAP: last = (cnt == 16'(IFG_LEN - 1));
            default: next_state = IDLE;
        endcase
        if (last) begin
            next_state = (state == GAP) ? IDLE : tx_state_e'(state + 3'd1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt <= '0;
            len_q <= 16'(MIN_DATA_LEN);
        end else begin
            state <= next_state;
            if (state == IDLE || last) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 16'd1;
            end
            if (start_ok) begin
                len_q <= cfg.data_len;
            end
        end
    end

    assign fcs = ~crc;

    always_comb begin
        case (state)
            PREAMBLE: tx_byte = PREAMBLE_BYTE;
            SFD: tx_byte = SFD_BYTE;
            HEADER: tx_byte = hdr_byte;
            PAYLOAD: tx_byte = fifo_data;
            FCS: tx_byte = fcs[{cnt[1:0], 3'b000} +: 8];  // Low byte goes first.
            default: tx_byte = 8'h00;
        endcase
    end

    assign eth_txd = tx_byte;
    assign eth_txen = (state != IDLE) && (state != GAP);
    assign done = (state == GAP) && (cnt == 16'd0);
    assign busy = (state != IDLE);

    assign hdr_idx = cnt[5:0];
    assign frame_start = start_ok;
    assign fifo_re = (state == PAYLOAD);

    // FCS covers header and payload only.
    assign crc_clr = start_ok;
    assign crc_en = (state == HEADER) || (state == PAYLOAD);
    assign crc_din = tx_byte;

endmodule

`default_nettype wire

//--- design/eth_tx_top.sv
`timescale 1ns/1ns
`default_nettype none

module eth_tx_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cfg_we,
    input  eth_tx_pkg::cfg_addr_e cfg_addr,
    input  logic [31:0]           cfg_wdata,
    input  logic                  payload_we,
    input  logic [7:0]            payload_data,
    input  logic                  start,
    output logic [7:0]            eth_txd,
    output logic                  eth_txen,
    output logic                  done,
    output logic                  busy
);
    import eth_tx_pkg::*;

    tx_cfg_t     cfg;
    logic        fifo_re;
    logic [7:0]  fifo_data;
    logic [6:0]  fifo_count;
    logic [5:0]  hdr_idx;
    logic [7:0]  hdr_byte;
    logic        frame_start;
    logic        crc_clr;
    logic        crc_en;
    logic [7:0]  crc_din;
    logic [31:0] crc;

    tx_config_regs u_regs (
        .clk, .rst, .cfg_we, .cfg_addr, .cfg_wdata, .cfg
    );

    // The full flag is not needed here since the FIFO drops overflow writes itself.
    payload_fifo u_fifo (
        .clk, .rst, .we(payload_we), .wr_data(payload_data), .re(fifo_re),
        .rd_data(fifo_data), .count(fifo_count), .full()
    );

    header_gen u_hdr (
        .clk, .rst, .cfg, .frame_start, .hdr_idx, .hdr_byte
    );

    crc32_gen u_crc (
        .clk, .rst, .clr(crc_clr), .en(crc_en), .din(crc_din), .crc
    );

    frame_tx u_frame (
        .clk, .rst, .start, .cfg, .fifo_count, .fifo_data, .fifo_re,
        .hdr_byte, .hdr_idx, .frame_start, .crc, .crc_clr, .crc_en, .crc_din,
        .eth_txd, .eth_txen, .done, .busy
    );

endmodule

`default_nettype wire

//--- dv/eth_tx_properties.sv
`timescale 1ns/1ns
`default_nettype none

module eth_tx_properties (
    input logic                  clk,
    input logic                  rst,
    input eth_tx_pkg::tx_state_e state,
    input logic                  start,
    input logic [15:0]           len_q,
    input logic                  eth_txen,
    input logic                  done
);
    import eth_tx_pkg::*;

    logic [16:0] run_len;  // Length of the current eth_txen run.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_len <= '0;
        end else if (eth_txen) begin
            run_len <= run_len + 17'd1;
        end else begin
            run_len <= '0;
        end
    end

    frame_len_check: assert property (@(posedge clk) disable iff (rst)
        $fell(eth_txen) |-> (run_len == 17'(PREAMBLE_LEN + 1 + HDR_LEN + FCS_LEN) + {1'b0, len_q}))
        else $error("eth_txen run length does not match the latched payload length");

    done_after_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(eth_txen) |-> done)
        else $error("done missing in the first cycle after eth_txen fell");

    done_only_after_fall: assert property (@(posedge clk) disable iff (rst)
        done |-> $fell(eth_txen))
        else $error("done raised without a frame ending");

    done_single: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done held longer than one cycle");

    // With start held, the sequencer reaches IDLE only once the whole gap has run.
    gap_no_start: assert property (@(posedge clk) disable iff (rst)
        (done && start) |-> ##IFG_LEN (state == IDLE))
        else $error("start accepted during the inter-frame gap");

endmodule

bind frame_tx eth_tx_properties props (
    .clk, .rst, .state, .start, .len_q, .eth_txen, .done
);

`default_nettype wire

//--- dv/tb_eth_tx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eth_tx;
    import eth_tx_pkg::*;

    typedef struct packed {
        logic [47:0] src_mac;
        logic [47:0] dst_mac;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] data_len;
        logic        late_start;    // Start goes up before any payload byte is written.
        logic        back_to_back;  // Two payloads, start held through the gap.
    } frame_case_t;

    logic        clk;
    logic        rst;
    logic        cfg_we;
    cfg_addr_e   cfg_addr;
    logic [31:0] cfg_wdata;
    logic        payload_we;
    logic [7:0]  payload_data;
    logic        start;
    logic [7:0]  eth_txd;
    logic        eth_txen;
    logic        done;
    logic        busy;

    frame_case_t cases [4];
    logic [7:0]  payload_q [$];
    logic [7:0]  exp_q [$];
    logic [7:0]  got_q [$];
    integer      seed;
    int          errors;
    int          limit;
    int          cycles = 0;

    eth_tx_top dut (
        .clk, .rst, .cfg_we, .cfg_addr, .cfg_wdata, .payload_we, .payload_data,
        .start, .eth_txd, .eth_txen, .done, .busy
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: the run was still going after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [15:0] ip_checksum(input logic [159:0] ip_hdr);
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + {16'h0000, ip_hdr[i * 16 +: 16]};
        end
        while (sum[31:16] != 16'h0000) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};  // End-around carry.
        end
        return ~sum[15:0];
    endfunction

    function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'h000000, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic build_expected(input frame_case_t fc, input int first,
                                  input logic [15:0] ident);
        logic [159:0] ip_hdr;
        logic [335:0] hdr;
        logic [31:0]  crc;
        ip_hdr = {16'h4500, fc.data_len + 16'd28, ident, 16'h0000, 8'd64, 8'h11, 16'h0000,
                  fc.src_ip, fc.dst_ip};
        ip_hdr[79:64] = ip_checksum(ip_hdr);
        hdr = {fc.dst_mac, fc.src_mac, 16'h0800, ip_hdr,
               fc.src_port, fc.dst_port, fc.data_len + 16'd8, 16'h0000};
        exp_q.delete();
        for (int i = 0; i < 7; i++) begin
            exp_q.push_back(8'h55);
        end
        exp_q.push_back(8'hD5);
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < 42; i++) begin
            exp_q.push_back(hdr[(41 - i) * 8 +: 8]);
            crc = crc32_update(crc, hdr[(41 - i) * 8 +: 8]);
        end
        for (int i = 0; i < int'(fc.data_len); i++) begin
            exp_q.push_back(payload_q[first + i]);
            crc = crc32_update(crc, payload_q[first + i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back(crc[i * 8 +: 8]);  // Low byte goes out first.
        end
    endtask

    task automatic write_reg(input cfg_addr_e addr, input logic [31:0] data);
        @(negedge clk);
        payload_we = 1'b0;
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
    endtask

    task automatic configure(input frame_case_t fc);
        write_reg(SRC_MAC_HI, {16'h0000, fc.src_mac[47:32]});
        write_reg(SRC_MAC_LO, fc.src_mac[31:0]);
        write_reg(DST_MAC_HI, {16'h0000, fc.dst_mac[47:32]});
        write_reg(DST_MAC_LO, fc.dst_mac[31:0]);
        write_reg(SRC_IP, fc.src_ip);
        write_reg(DST_IP, fc.dst_ip);
        write_reg(PORTS, {fc.src_port, fc.dst_port});
        write_reg(DATA_LEN, {16'h0000, fc.data_len});
    endtask

    task automatic load_payload(input int n, input logic expect_idle);
        integer rnd;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (expect_idle) begin
                assert (!eth_txen) else begin
                    $display("frame started with only %0d of %0d payload bytes written", i, n);
                    errors++;
                end
            end
            rnd = $random(seed);
            cfg_we = 1'b0;
            payload_we = 1'b1;
            payload_data = rnd[7:0];
            payload_q.push_back(rnd[7:0]);
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change.
    task automatic capture_frame(output int low_cycles);
        got_q.delete();
        low_cycles = 0;
        @(negedge clk);
        while (!eth_txen) begin
            low_cycles++;
            @(negedge clk);
        end
        while (eth_txen) begin
            got_q.push_back(eth_txd);
            assert (busy) else begin
                $display("busy was low while eth_txen was high");
                errors++;
            end
            @(negedge clk);
        end
        assert (done && busy) else begin
            $display("done or busy was low in the first cycle after the frame");
            errors++;
        end
    endtask

    task automatic compare_frame();
        int n;
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        assert (got_q.size() == exp_q.size()) else begin
            $display("MISMATCH eth_txen cycles: expected %h, got %h", exp_q.size(), got_q.size());
            errors++;
        end
        for (int i = 0; i < n; i++) begin
            assert (got_q[i] == exp_q[i]) else begin
                $display("MISMATCH eth_txd byte %0d: expected %h, got %h", i, exp_q[i], got_q[i]);
                errors++;
            end
        end
    endtask

    initial begin
        frame_case_t fc;
        int          low;
        int          dl;
        int          frames;
        int          errs_before;
        int          tests_failed;
        logic [15:0] ident;
        rst = 1'b1;
        cfg_we = 1'b0;
        cfg_addr = SRC_MAC_HI;
        cfg_wdata = '0;
        payload_we = 1'b0;
        payload_data = '0;
        start = 1'b0;
        seed = 59904;
        errors = 0;
        tests_failed = 0;
        ident = 16'd0;
        cases[0] = '{48'h02A0_B1C2_D3E4, 48'h001B_213A_4C5D, 32'hC0A8_0101, 32'hC0A8_0164,
                     16'd5000, 16'd6000, 16'd18, 1'b0, 1'b0};
        cases[1] = '{48'h0211_2233_4455, 48'h3CFD_FE01_0203, 32'h0A00_0002, 32'h0A00_00FE,
                     16'h1234, 16'hABCD, 16'd64, 1'b0, 1'b0};
        cases[2] = '{48'h02DE_AD00_BEEF, 48'hFFFF_FFFF_FFFF, 32'hAC10_0A05, 32'hAC10_FFFF,
                     16'd68, 16'd67, 16'd30, 1'b1, 1'b0};
        cases[3] = '{48'h0A0B_0C0D_0E0F, 48'h1020_3040_5060, 32'hFFFE_FDFC, 32'h0102_0304,
                     16'hFFFF, 16'h0001, 16'd24, 1'b0, 1'b1};
        limit = 10 + 200;
        for (int r = 0; r < 4; r++) begin
            frames = cases[r].back_to_back ? 2 : 1;
            dl = int'(cases[r].data_len);
            limit += 8 + 2 + frames * dl + frames * (54 + dl + IFG_LEN + 1);
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        assert (!eth_txen && !done && !busy) else begin
            $display("eth_txen, done or busy was high after reset");
            errors++;
        end
        for (int r = 0; r < 4; r++) begin
            fc = cases[r];
            dl = int'(fc.data_len);
            frames = fc.back_to_back ? 2 : 1;
            errs_before = errors;
            payload_q.delete();
            configure(fc);
            if (fc.late_start) begin
                @(negedge clk);
                cfg_we = 1'b0;
                start = 1'b1;
                load_payload(dl, 1'b1);
                @(negedge clk);
                payload_we = 1'b0;
            end else begin
                load_payload(frames * dl, 1'b0);
                @(negedge clk);
                cfg_we = 1'b0;
                payload_we = 1'b0;
                start = 1'b1;
            end
            capture_frame(low);
            assert (low == 0) else begin
                $display("frame did not start on the edge after start was accepted");
                errors++;
            end
            build_expected(fc, 0, ident);
            compare_frame();
            ident = ident + 16'd1;
            if (fc.back_to_back) begin
                capture_frame(low);
                assert (low >= IFG_LEN) else begin
                    $display("second frame followed the first after only %0d idle cycles", low);
                    errors++;
                end
                build_expected(fc, dl, ident);
                compare_frame();
                ident = ident + 16'd1;
            end
            start = 1'b0;
            if (errors != errs_before) begin
                tests_failed++;
            end
            $display("test %0d: data_len %0d, %0d frame(s), %0d error(s)", r, dl, frames,
                     errors - errs_before);
        end
        $display("tests passed: %0d, tests failed: %0d", 4 - tests_failed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
design/eth_tx_pkg.sv
design/tx_config_regs.sv
design/payload_fifo.sv
design/crc32_gen.sv
design/header_gen.sv
design/frame_tx.sv
design/eth_tx_top.sv
dv/eth_tx_properties.sv
dv/tb_eth_tx.sv

//--- run_sim.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_eth_tx -f all.f -o sim_eth_tx
./obj_dir/sim_eth_tx | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
